// File: design/split_pkg.sv
/*
 * shared definitions for the alignment stream splitter
 * stream and lane widths, word types, the job state enum and the
 * read-only APB register map
 */
package split_pkg;

    ////////////////////////////////////////
    // stream geometry
    ////////////////////////////////////////

    // input stream and lane 2 width
    localparam int stream_w      = 128;
    // one base on the input stream takes a full byte
    localparam int stream_base_w = 8;
    // one base on lane 1 is packed to two bits
    localparam int int_base_w    = 2;
    // bases carried by one input word
    localparam int bases_per_tx  = 16;
    // lane 1 width, sixteen packed bases
    localparam int int_stream_w  = 32;
    // length field in the low bits of a query or target header
    localparam int len_w         = 12;
    // parameter words at the end of each job, sent to lane 2 only
    localparam int num_extra_tx  = 6;

    typedef logic [stream_w-1:0]     stream_word_t;
    typedef logic [int_stream_w-1:0] lane1_word_t;
    // also wide enough for the transfer countdown (at most 129 per sequence)
    typedef logic [len_w-1:0]        seq_len_t;
    typedef logic [31:0]             reg_word_t;

    // job phases, the query first, then the target, then the parameter words
    typedef enum logic [2:0] {
        info_q,
        header_q,
        data_q,
        info_t,
        header_t,
        data_t,
        load_extra,
        extra
    } split_state_t;

    ////////////////////////////////////////
    // APB register map
    ////////////////////////////////////////

    localparam reg_word_t split_version = 32'h0000_0002;

    // byte addresses of the readable registers
    localparam logic [7:0] reg_addr_version    = 8'h00;
    localparam logic [7:0] reg_addr_in_count   = 8'h10;
    localparam logic [7:0] reg_addr_out1_count = 8'h20;
    localparam logic [7:0] reg_addr_out2_count = 8'h30;

endpackage

// File: design/split_lane_if.sv
`timescale 1ns/1ps

/*
 * control bundle between the job sequencer and the two output lane
 * registers: load strobes, the lane 1 packing select and the lane space flags
 */
interface split_lane_if import split_pkg::*; ();

    // load strobes, one pulse per accepted input word
    logic load_1;
    logic load_2;

    // high while base words pass, lane 1 then packs instead of truncating
    logic convert;

    // a lane register can take a word when it is empty or drains this cycle
    logic can_load_1;
    logic can_load_2;

    // the sequencer decides what gets loaded and where
    modport seq (
        output load_1,
        output load_2,
        output convert,
        input  can_load_1,
        input  can_load_2
    );

    // the lane registers report back whether they have room
    modport lanes (
        input  load_1,
        input  load_2,
        input  convert,
        output can_load_1,
        output can_load_2
    );

endinterface

// File: design/split_sequencer.sv
`timescale 1ns/1ps

/*
 * job sequencer for the alignment stream splitter
 * walks the query, target and parameter phases of each job, keeps the
 * remaining transfer count and raises input ready from the lane flags
 */
module split_sequencer import split_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         in_valid,
    input  stream_word_t in_data,
    output logic         in_rdy,
    split_lane_if.seq    lane
);

    split_state_t state;
    split_state_t next_state;

    // words left in the current phase, header included
    seq_len_t tx_remaining;

    // length field of the word waiting at the input
    seq_len_t in_len;
    // set when the length does not fill the last base word
    logic     len_partial;
    // header plus the base words it announces
    seq_len_t job_words;

    logic accept;
    logic last_tx;

    ////////////////////////////////////////
    // transfer count
    ////////////////////////////////////////

    // query and target headers keep the length in the same low field
    assign in_len      = in_data[len_w-1:0];
    assign len_partial = |in_len[$clog2(bases_per_tx)-1:0];

    // one header word plus ceil(length / 16) base words
    assign job_words = (in_len >> $clog2(bases_per_tx))
                     + seq_len_t'(len_partial)
                     + seq_len_t'(1);

    assign accept  = in_valid && in_rdy;
    assign last_tx = (tx_remaining == seq_len_t'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_remaining <= '0;
        end else if (state == load_extra) begin
            tx_remaining <= seq_len_t'(num_extra_tx);
        end else if ((state == info_q || state == info_t) && in_valid) begin
            // peek at the header without taking it, it is accepted next state
            tx_remaining <= job_words;
        end else if (accept) begin
            tx_remaining <= tx_remaining - seq_len_t'(1);
        end
    end

    ////////////////////////////////////////
    // job FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= info_q;
        end else begin
            state <= next_state;
        end
    end

    // headers and bases need room on both lanes, parameter words only on lane 2
    always_comb begin
        case (state)
            header_q, data_q, header_t, data_t: begin
                in_rdy = lane.can_load_1 && lane.can_load_2;
            end
            extra: begin
                in_rdy = lane.can_load_2;
            end
            default: begin
                // info and load_extra are bookkeeping cycles
                in_rdy = 1'b0;
            end
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            info_q: begin
                if (in_valid) begin
                    next_state = header_q;
                end
            end
            header_q: begin
                if (accept) begin
                    next_state = data_q;
                end
            end
            data_q: begin
                if (accept && last_tx) begin
                    next_state = info_t;
                end
            end
            info_t: begin
                if (in_valid) begin
                    next_state = header_t;
                end
            end
            header_t: begin
                if (accept) begin
                    next_state = data_t;
                end
            end
            data_t: begin
                if (accept && last_tx) begin
                    next_state = load_extra;
                end
            end
            load_extra: begin
                next_state = extra;
            end
            extra: begin
                if (accept && last_tx) begin
                    next_state = info_q;
                end
            end
            default: begin
                next_state = info_q;
            end
        endcase
    end

    // ready is low outside header, data and extra, so accept implies one of them
    assign lane.load_1  = accept && (state != extra);
    assign lane.load_2  = accept;
    assign lane.convert = (state == data_q) || (state == data_t);

endmodule

// File: design/split_out_regs.sv
`timescale 1ns/1ps

/*
 * output registers of the two lanes
 * lane 1 gets truncated headers and packed 2-bit bases, lane 2 gets every
 * input word unchanged
 */
module split_out_regs import split_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  stream_word_t in_data,
    split_lane_if.lanes  lane,
    input  logic         out1_rdy,
    input  logic         out2_rdy,
    output logic         out1_valid,
    output logic         out2_valid,
    output lane1_word_t  out1_data,
    output stream_word_t out2_data
);

    lane1_word_t packed_bases;
    lane1_word_t lane1_next;

    ////////////////////////////////////////
    // lane 1 data path
    ////////////////////////////////////////

    // base i sits in input byte i, only its two low bits carry the code
    always_comb begin
        packed_bases = '0;
        for (int i = 0; i < bases_per_tx; i++) begin
            packed_bases[i*int_base_w +: int_base_w] =
                in_data[i*stream_base_w +: int_base_w];
        end
    end

    // headers keep only their low word, which holds the length field
    assign lane1_next = lane.convert ? packed_bases : in_data[int_stream_w-1:0];

    // room when empty, or when the word held now leaves on this edge
    assign lane.can_load_1 = !out1_valid || out1_rdy;
    assign lane.can_load_2 = !out2_valid || out2_rdy;

    ////////////////////////////////////////
    // lane registers
    ////////////////////////////////////////

    // a reload on the accept edge keeps the register full
    always_ff @(posedge clk) begin
        if (rst) begin
            out1_valid <= 1'b0;
        end else if (lane.load_1) begin
            out1_valid <= 1'b1;
        end else if (out1_valid && out1_rdy) begin
            out1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (lane.load_1) begin
            out1_data <= lane1_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out2_valid <= 1'b0;
        end else if (lane.load_2) begin
            out2_valid <= 1'b1;
        end else if (out2_valid && out2_rdy) begin
            out2_valid <= 1'b0;
        end
    end

    // parameter words share this path, lane 2 never changes the data
    always_ff @(posedge clk) begin
        if (lane.load_2) begin
            out2_data <= in_data;
        end
    end

endmodule

// File: design/split_stats.sv
`timescale 1ns/1ps

/*
 * transfer counters and read-only APB register file
 * counts completed transfers on the input and both lanes
 */
module split_stats import split_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  logic       in_rdy,
    input  logic       out1_valid,
    input  logic       out1_rdy,
    input  logic       out2_valid,
    input  logic       out2_rdy,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  logic [7:0] paddr,
    output reg_word_t  prdata,
    output logic       pready
);

    reg_word_t in_count;
    reg_word_t out1_count;
    reg_word_t out2_count;

    // register selected by the current address
    reg_word_t read_word;
    logic      read_access;

    ////////////////////////////////////////
    // transfer counters
    ////////////////////////////////////////

    // each counter steps on the same edge as the transfer it counts
    always_ff @(posedge clk) begin
        if (rst) begin
            in_count   <= '0;
            out1_count <= '0;
            out2_count <= '0;
        end else begin
            if (in_valid && in_rdy) begin
                in_count <= in_count + reg_word_t'(1);
            end
            if (out1_valid && out1_rdy) begin
                out1_count <= out1_count + reg_word_t'(1);
            end
            if (out2_valid && out2_rdy) begin
                out2_count <= out2_count + reg_word_t'(1);
            end
        end
    end

    ////////////////////////////////////////
    // APB read port
    ////////////////////////////////////////

    always_comb begin
        case (paddr)
            reg_addr_version:    read_word = split_version;
            reg_addr_in_count:   read_word = in_count;
            reg_addr_out1_count: read_word = out1_count;
            reg_addr_out2_count: read_word = out2_count;
            // holes in the map read as zero
            default:             read_word = '0;
        endcase
    end

    // data shows in the access phase, counts as of the previous edge
    assign read_access = psel && penable && !pwrite;
    assign prdata      = read_access ? read_word : '0;

    // no wait states, writes finish at once and change nothing
    assign pready = 1'b1;

endmodule

// File: design/split_stream_top.sv
`timescale 1ns/1ps

/*
 * alignment stream splitter top level
 * one 128-bit job stream in, a packed lane 1 and a full-width lane 2 out,
 * transfer counters on an APB slave
 */
module split_stream_top import split_pkg::*; (
    input  logic         clk,
    input  logic         rst,

    // job stream
    input  logic         in_valid,
    output logic         in_rdy,
    input  stream_word_t in_data,

    // lane 1, truncated headers and packed bases
    output logic         out1_valid,
    input  logic         out1_rdy,
    output lane1_word_t  out1_data,

    // lane 2, every input word including the parameter words
    output logic         out2_valid,
    input  logic         out2_rdy,
    output stream_word_t out2_data,

    // APB slave, write data is taken but nothing is writable
    input  logic         psel,
    input  logic         penable,
    input  logic         pwrite,
    input  logic [7:0]   paddr,
    input  reg_word_t    pwdata,
    output reg_word_t    prdata,
    output logic         pready
);

    // strobes and space flags between the sequencer and the lane registers
    split_lane_if lane_bus ();

    split_sequencer u_sequencer (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_rdy   (in_rdy),
        .lane     (lane_bus.seq)
    );

    split_out_regs u_out_regs (
        .clk        (clk),
        .rst        (rst),
        .in_data    (in_data),
        .lane       (lane_bus.lanes),
        .out1_rdy   (out1_rdy),
        .out2_rdy   (out2_rdy),
        .out1_valid (out1_valid),
        .out2_valid (out2_valid),
        .out1_data  (out1_data),
        .out2_data  (out2_data)
    );

    // the counters watch the handshakes at the ports themselves
    split_stats u_stats (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_rdy     (in_rdy),
        .out1_valid (out1_valid),
        .out1_rdy   (out1_rdy),
        .out2_valid (out2_valid),
        .out2_rdy   (out2_rdy),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .prdata     (prdata),
        .pready     (pready)
    );

endmodule

// File: verification/split_stream_assert.sv
`timescale 1ns/1ps

/*
 * handshake assertions for the alignment stream splitter
 * output hold under back-pressure, input ready after reset, APB ready
 */
module split_stream_assert import split_pkg::*; (
    input logic         clk,
    input logic         rst,
    input logic         in_rdy,
    input logic         out1_valid,
    input logic         out1_rdy,
    input lane1_word_t  out1_data,
    input logic         out2_valid,
    input logic         out2_rdy,
    input stream_word_t out2_data,
    input logic         psel,
    input logic         penable,
    input logic         pwrite,
    input logic         pready
);

    // a stalled lane keeps its word until the consumer takes it
    out1_hold: assert property (@(posedge clk) disable iff (rst)
        out1_valid && !out1_rdy |=> out1_valid && $stable(out1_data))
        else $error("lane 1 word dropped or changed while stalled");

    out2_hold: assert property (@(posedge clk) disable iff (rst)
        out2_valid && !out2_rdy |=> out2_valid && $stable(out2_data))
        else $error("lane 2 word dropped or changed while stalled");

    // the FSM starts in info_q, which never takes input
    rdy_after_reset: assert property (@(posedge clk) $fell(rst) |-> !in_rdy)
        else $error("input ready high in the first cycle after reset");

    // the slave has no wait states
    apb_no_wait: assert property (@(posedge clk) disable iff (rst)
        psel && penable && !pwrite |-> pready)
        else $error("APB read access phase without pready");

endmodule

bind split_stream_top split_stream_assert assert_i (
    .clk        (clk),
    .rst        (rst),
    .in_rdy     (in_rdy),
    .out1_valid (out1_valid),
    .out1_rdy   (out1_rdy),
    .out1_data  (out1_data),
    .out2_valid (out2_valid),
    .out2_rdy   (out2_rdy),
    .out2_data  (out2_data),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pready     (pready)
);

// File: verification/split_stream_tb.sv
`timescale 1ns/1ps

/*
 * testbench for the alignment stream splitter
 * runs a table of jobs under lane stalls, compares both lanes with a
 * reference model and reads the transfer counters over APB
 */
module split_stream_tb import split_pkg::*; ();

    typedef struct packed {
        seq_len_t    q_len;
        seq_len_t    t_len;
        logic [15:0] stall_1;
        logic [15:0] stall_2;
    } job_row_t;

    localparam int num_jobs    = 6;
    localparam int job_timeout = 8000;
    localparam int apb_timeout = 16;

    // a set stall bit holds that lane's ready low in the matching cycle
    localparam job_row_t job_table [num_jobs] = '{
        '{12'd1,    12'd16,   16'h0000, 16'h0000},
        '{12'd17,   12'd1,    16'h0000, 16'h0000},
        '{12'd16,   12'd17,   16'h0f0f, 16'h0000},
        '{12'd33,   12'd2,    16'h0000, 16'h3c3c},
        '{12'd2048, 12'd31,   16'h9249, 16'h4924},
        '{12'd100,  12'd2048, 16'h0001, 16'h00ff}
    };

    logic         clk;
    logic         rst;
    logic         in_valid;
    logic         in_rdy;
    stream_word_t in_data;
    logic         out1_valid;
    logic         out1_rdy;
    lane1_word_t  out1_data;
    logic         out2_valid;
    logic         out2_rdy;
    stream_word_t out2_data;
    logic         psel;
    logic         penable;
    logic         pwrite;
    logic [7:0]   paddr;
    reg_word_t    pwdata;
    reg_word_t    prdata;
    logic         pready;

    // words to drive and the words each lane should deliver, in order
    stream_word_t in_words[$];
    lane1_word_t  exp_lane1[$];
    stream_word_t exp_lane2[$];
    int           in_idx;
    reg_word_t    total_in;
    reg_word_t    total_1;
    reg_word_t    total_2;
    logic [31:0]  lcg_state = 32'h0344e8b3;

    split_stream_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_rdy     (in_rdy),
        .in_data    (in_data),
        .out1_valid (out1_valid),
        .out1_rdy   (out1_rdy),
        .out1_data  (out1_data),
        .out2_valid (out2_valid),
        .out2_rdy   (out2_rdy),
        .out2_data  (out2_data),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic stream_word_t random_word();
        return {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
    endfunction

    // base b is the low two bits of byte b, placed at lane 1 bits 2b and 2b+1
    function automatic lane1_word_t expect_packed(stream_word_t word);
        lane1_word_t result;
        result = '0;
        for (int b = 0; b < 16; b++) begin
            result[2*b +: 2] = word[8*b +: 2];
        end
        return result;
    endfunction

    task automatic stop_on_failure();
        $display("Checks failed");
        $fatal(1, "stopping at the first failure");
    endtask

    // every word goes to lane 2, headers and bases also to lane 1
    task automatic add_word(stream_word_t word, logic to_lane1, logic is_base);
        in_words.push_back(word);
        exp_lane2.push_back(word);
        total_in = total_in + 32'd1;
        total_2  = total_2 + 32'd1;
        if (to_lane1) begin
            exp_lane1.push_back(is_base ? expect_packed(word) : word[31:0]);
            total_1 = total_1 + 32'd1;
        end
    endtask

    // random upper header bits show that only the length field counts
    task automatic add_sequence(seq_len_t len);
        stream_word_t header;
        header           = random_word();
        header[11:0]     = len;
        add_word(header, 1'b1, 1'b0);
        for (int w = 0; w < (int'(len) + 15) / 16; w++) begin
            add_word(random_word(), 1'b1, 1'b1);
        end
    endtask

    ////////////////////////////////////////
    // checks and bus tasks
    ////////////////////////////////////////

    task automatic check_lane1(string name, lane1_word_t expected, lane1_word_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_lane2(string name, stream_word_t expected, stream_word_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_reg(string name, reg_word_t expected, reg_word_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %b, got %b",
                     $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    // setup then access phase, the loop waits for pready
    task automatic apb_access(logic [7:0] addr, logic write, reg_word_t wdata,
                              output reg_word_t rdata);
        int wait_cycles;
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #2;
        wait_cycles = 0;
        while (!pready) begin
            if (wait_cycles == apb_timeout) begin
                $display("APB access at address %h never saw pready", addr);
                stop_on_failure();
            end
            @(posedge clk);
            #3;
            wait_cycles++;
        end
        rdata = prdata;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_and_check(logic [7:0] addr, string name, reg_word_t expected);
        reg_word_t value;
        apb_access(addr, 1'b0, '0, value);
        check_reg(name, expected, value);
    endtask

    ////////////////////////////////////////
    // job driver
    ////////////////////////////////////////

    // drive at +1 ns, sample the handshakes at +3 ns for the coming edge
    task automatic run_job(job_row_t row);
        int         cycles;
        logic [3:0] phase;
        cycles = 0;
        phase  = '0;
        in_words.delete();
        in_idx = 0;
        add_sequence(row.q_len);
        add_sequence(row.t_len);
        for (int p = 0; p < 6; p++) begin
            add_word(random_word(), 1'b0, 1'b0);
        end
        while (in_idx < in_words.size() || exp_lane1.size() > 0 || exp_lane2.size() > 0) begin
            if (cycles == job_timeout) begin
                $display("job with lengths %0d and %0d did not drain in time",
                         row.q_len, row.t_len);
                stop_on_failure();
            end
            @(posedge clk);
            #1;
            in_valid = (in_idx < in_words.size());
            in_data  = in_valid ? in_words[in_idx] : '0;
            out1_rdy = !row.stall_1[phase];
            out2_rdy = !row.stall_2[phase];
            #2;
            if (in_valid && in_rdy) begin
                in_idx++;
            end
            if (out1_valid && out1_rdy) begin
                if (exp_lane1.size() == 0) begin
                    $display("lane 1 delivered a word that was never expected");
                    stop_on_failure();
                end
                check_lane1("out1_data", exp_lane1.pop_front(), out1_data);
            end
            if (out2_valid && out2_rdy) begin
                if (exp_lane2.size() == 0) begin
                    $display("lane 2 delivered a word that was never expected");
                    stop_on_failure();
                end
                check_lane2("out2_data", exp_lane2.pop_front(), out2_data);
            end
            phase = phase + 4'd1;
            cycles++;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in_data  = '0;
    endtask

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        in_data  = '0;
        out1_rdy = 1'b0;
        out2_rdy = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        total_in = '0;
        total_1  = '0;
        total_2  = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // idle after reset with all counters cleared
        @(posedge clk);
        #3;
        check_flag("in_rdy", 1'b0, in_rdy);
        check_flag("out1_valid", 1'b0, out1_valid);
        check_flag("out2_valid", 1'b0, out2_valid);
        read_and_check(reg_addr_in_count, "in_count", '0);
        read_and_check(reg_addr_out1_count, "out1_count", '0);
        read_and_check(reg_addr_out2_count, "out2_count", '0);

        for (int j = 0; j < num_jobs; j++) begin
            run_job(job_table[j]);
        end

        read_and_check(reg_addr_in_count, "in_count", total_in);
        read_and_check(reg_addr_out1_count, "out1_count", total_1);
        read_and_check(reg_addr_out2_count, "out2_count", total_2);
        read_and_check(8'h00, "version", 32'h0000_0002);
        read_and_check(8'h44, "unmapped", '0);

        // writes land nowhere, every register reads back as before
        begin
            reg_word_t ignored;
            apb_access(reg_addr_in_count, 1'b1, 32'h5a5a_a5a5, ignored);
            apb_access(reg_addr_version, 1'b1, 32'hffff_ffff, ignored);
        end
        read_and_check(reg_addr_in_count, "in_count", total_in);
        read_and_check(reg_addr_out1_count, "out1_count", total_1);
        read_and_check(reg_addr_out2_count, "out2_count", total_2);
        read_and_check(8'h00, "version", 32'h0000_0002);

        $display("All checks passed");
        $finish;
    end

endmodule

// File: list.f
design/split_pkg.sv
design/split_lane_if.sv
design/split_sequencer.sv
design/split_out_regs.sv
design/split_stats.sv
design/split_stream_top.sv
verification/split_stream_assert.sv
verification/split_stream_tb.sv

// File: Makefile
# Verilator lint and simulation of the alignment stream splitter

VERILATOR  ?= verilator
TOP        := split_stream_tb
FILE_LIST  := list.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
PASS_MSG   := All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

# the run passes only when the log holds the pass message
sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
